// ==== butterfly.f ====
+incdir+include
logic/fft_fixed_pkg.sv
logic/cmult_if.sv
logic/twiddle_rom.sv
logic/complex_mult.sv
logic/butterfly.sv
logic/butterfly_top.sv
sim/tb_butterfly_top.sv

// ==== include/fft_params.svh ====
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

// one word per real or imaginary part, two's complement
`define FFT_N 32

// fraction bits of every word, Q16.16 with the width above
`define FFT_D 16

// product units inside complex_mult
// 1 shares one unit over three cycles, 3 is fully combinational
`define FFT_NUM_MULTS 1

// twiddle index width, k selects W8^k for k from 0 to 3
`define FFT_TW_BITS 2

`endif

// ==== logic/butterfly.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fft_params.svh"

// radix-2 DIT butterfly, x0 = a + b*W and x1 = a - b*W
// a waits in a holding register while the multiplier works on b*W
module butterfly (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_val,
  output logic              in_rdy,
  input  logic [`FFT_N-1:0] a_re,
  input  logic [`FFT_N-1:0] a_im,
  input  logic [`FFT_N-1:0] b_re,
  input  logic [`FFT_N-1:0] b_im,
  input  logic [`FFT_N-1:0] tw_re,
  input  logic [`FFT_N-1:0] tw_im,
  output logic              out_val,
  input  logic              out_rdy,
  output logic [`FFT_N-1:0] x0_re,
  output logic [`FFT_N-1:0] x0_im,
  output logic [`FFT_N-1:0] x1_re,
  output logic [`FFT_N-1:0] x1_im,
  cmult_if.requester        m
);

  logic              a_busy;     // a is held for a product still in flight
  logic [`FFT_N-1:0] a_re_q;
  logic [`FFT_N-1:0] a_im_q;
  logic [`FFT_N-1:0] a_re_sel;
  logic [`FFT_N-1:0] a_im_sel;
  logic              out_free;   // output register empty or emptying now
  logic              in_fire;
  logic              take;       // product lands in the output register

  assign out_free = !out_val || out_rdy;

  // the input request goes to the multiplier as is
  assign m.recv_val = in_val && !a_busy;
  assign m.ar       = b_re;
  assign m.ac       = b_im;
  assign m.br       = tw_re;
  assign m.bc       = tw_im;
  assign m.send_rdy = out_free;

  assign in_rdy  = !a_busy && m.recv_rdy;
  assign in_fire = in_val && in_rdy;
  assign take    = m.send_val && out_free;

  // with a combinational multiplier the product arrives while a is still on
  // the input pins, so a is only read from the register when it is held
  assign a_re_sel = a_busy ? a_re_q : a_re;
  assign a_im_sel = a_busy ? a_im_q : a_im;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_busy <= 1'b0;
    end else if (in_fire && !take) begin
      a_busy <= 1'b1;
    end else if (take) begin
      a_busy <= 1'b0;              // product consumed, a is free again
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      a_re_q <= a_re;
      a_im_q <= a_im;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_val <= 1'b0;
    end else if (take) begin
      out_val <= 1'b1;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      x0_re <= a_re_sel + m.cr;    // wraps like the multiplier sums
      x0_im <= a_im_sel + m.cc;
      x1_re <= a_re_sel - m.cr;
      x1_im <= a_im_sel - m.cc;
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(x0_re) && $stable(x0_im)
      && $stable(x1_re) && $stable(x1_im)
  ) else $error("butterfly output changed while stalled");

  // the held a must not be overwritten by a new request
  a_no_accept_busy: assert property (
    @(posedge clk) disable iff (reset)
    a_busy && !take |=> a_busy && $stable(a_re_q) && $stable(a_im_q)
  ) else $error("butterfly dropped or overwrote operand a while it was held");

endmodule

`default_nettype wire

// ==== logic/butterfly_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fft_params.svh"

// butterfly with its twiddle table and complex multiplier, plain ports only
module butterfly_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_val,
  output logic                    in_rdy,
  input  logic [`FFT_N-1:0]       a_re,
  input  logic [`FFT_N-1:0]       a_im,
  input  logic [`FFT_N-1:0]       b_re,
  input  logic [`FFT_N-1:0]       b_im,
  input  logic [`FFT_TW_BITS-1:0] k,
  output logic                    out_val,
  input  logic                    out_rdy,
  output logic [`FFT_N-1:0]       x0_re,
  output logic [`FFT_N-1:0]       x0_im,
  output logic [`FFT_N-1:0]       x1_re,
  output logic [`FFT_N-1:0]       x1_im
);

  logic [`FFT_N-1:0] tw_re;
  logic [`FFT_N-1:0] tw_im;

  cmult_if cmult_bus ();

  twiddle_rom twiddle_rom_i (
    .k     (k),
    .tw_re (tw_re),
    .tw_im (tw_im)
  );

  complex_mult complex_mult_i (
    .clk   (clk),
    .reset (reset),
    .m     (cmult_bus.multiplier)
  );

  butterfly butterfly_i (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .a_re    (a_re),
    .a_im    (a_im),
    .b_re    (b_re),
    .b_im    (b_im),
    .tw_re   (tw_re),
    .tw_im   (tw_im),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .x0_re   (x0_re),
    .x0_im   (x0_im),
    .x1_re   (x1_re),
    .x1_im   (x1_im),
    .m       (cmult_bus.requester)
  );

endmodule

`default_nettype wire

// ==== logic/cmult_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fft_params.svh"

// one complex multiply request c = a * b and its result
interface cmult_if;

  logic              recv_val;   // request side
  logic              recv_rdy;
  logic [`FFT_N-1:0] ar;         // real part of a
  logic [`FFT_N-1:0] ac;         // imaginary part of a
  logic [`FFT_N-1:0] br;
  logic [`FFT_N-1:0] bc;

  logic              send_val;   // result side
  logic              send_rdy;
  logic [`FFT_N-1:0] cr;
  logic [`FFT_N-1:0] cc;

  modport requester (
    output recv_val, ar, ac, br, bc, send_rdy,
    input  recv_rdy, send_val, cr, cc
  );

  modport multiplier (
    input  recv_val, ar, ac, br, bc, send_rdy,
    output recv_rdy, send_val, cr, cc
  );

endinterface

`default_nettype wire

// ==== logic/complex_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fft_params.svh"

// complex multiplier c = a * b with three real products
//   cr = ar*br - ac*bc
//   cc = (ar + ac)*(br + bc) - ar*br - ac*bc
// every sum and difference wraps at the word width
module complex_mult
  import fft_fixed_pkg::*;
(
  input logic         clk,
  input logic         reset,
  cmult_if.multiplier m
);

  localparam logic [2:0] IDLE = 3'd0;
  localparam logic [2:0] MUL1 = 3'd1;
  localparam logic [2:0] MUL2 = 3'd2;
  localparam logic [2:0] MUL3 = 3'd3;
  localparam logic [2:0] DONE = 3'd4;

  generate
    if (`FFT_NUM_MULTS == 3) begin : g_three
      logic [`FFT_N-1:0] p_rr;     // ar * br
      logic [`FFT_N-1:0] p_cc;     // ac * bc
      logic [`FFT_N-1:0] p_sum;    // (ar + ac) * (br + bc)
      logic [`FFT_N-1:0] a_sum;
      logic [`FFT_N-1:0] b_sum;

      // three units side by side, the result is ready in the request cycle
      always_comb begin
        a_sum = m.ar + m.ac;
        b_sum = m.br + m.bc;
        p_rr  = fixed_mul(m.ar, m.br);
        p_cc  = fixed_mul(m.ac, m.bc);
        p_sum = fixed_mul(a_sum, b_sum);
      end

      assign m.cr       = p_rr - p_cc;
      assign m.cc       = p_sum - p_rr - p_cc;
      assign m.send_val = m.recv_val;    // valid passes straight through
      assign m.recv_rdy = m.send_rdy;    // and so does ready, backwards
    end else begin : g_one
      logic [2:0]        state;
      logic [2:0]        next_state;
      logic [`FFT_N-1:0] ar_q;
      logic [`FFT_N-1:0] ac_q;
      logic [`FFT_N-1:0] br_q;
      logic [`FFT_N-1:0] bc_q;
      logic [`FFT_N-1:0] p_rr;
      logic [`FFT_N-1:0] p_cc;
      logic [`FFT_N-1:0] p_sum;
      logic [`FFT_N-1:0] mul_a;
      logic [`FFT_N-1:0] mul_b;
      logic [`FFT_N-1:0] mul_c;

      always_ff @(posedge clk) begin
        if (reset) begin
          state <= IDLE;
        end else begin
          state <= next_state;
        end
      end

      // operand capture and one product per MUL state
      always_ff @(posedge clk) begin
        case (state)
          IDLE: begin
            if (m.recv_val) begin
              ar_q <= m.ar;
              ac_q <= m.ac;
              br_q <= m.br;
              bc_q <= m.bc;
            end
          end
          MUL1: p_rr  <= mul_c;
          MUL2: p_cc  <= mul_c;
          MUL3: p_sum <= mul_c;
          default: begin
          end
        endcase
      end

      always_comb begin
        next_state = state;
        m.recv_rdy = 1'b0;
        m.send_val = 1'b0;
        mul_a      = ar_q;               // the shared unit idles on ar * br
        mul_b      = br_q;
        case (state)
          IDLE: begin
            m.recv_rdy = 1'b1;
            if (m.recv_val) next_state = MUL1;
          end
          MUL1: begin
            next_state = MUL2;
          end
          MUL2: begin
            mul_a      = ac_q;
            mul_b      = bc_q;
            next_state = MUL3;
          end
          MUL3: begin
            mul_a      = ar_q + ac_q;
            mul_b      = br_q + bc_q;
            next_state = DONE;
          end
          DONE: begin
            m.send_val = 1'b1;
            if (m.send_rdy) next_state = IDLE;
          end
          default: begin
            next_state = IDLE;
          end
        endcase
      end

      assign mul_c = fixed_mul(mul_a, mul_b);   // the one shared product unit

      // products are all registered by DONE, so the result holds there
      assign m.cr = p_rr - p_cc;
      assign m.cc = p_sum - p_rr - p_cc;
    end
  endgenerate

  // a result offered and not taken stays offered and unchanged
  // (in the combinational build this relies on the requester holding its request)
  a_result_held: assert property (
    @(posedge clk) disable iff (reset)
    m.send_val && !m.send_rdy |=> m.send_val && $stable(m.cr) && $stable(m.cc)
  ) else $error("complex_mult dropped or changed a pending result");

endmodule

`default_nettype wire

// ==== logic/fft_fixed_pkg.sv ====
`default_nettype none

`include "fft_params.svh"

package fft_fixed_pkg;

  // one fixed-point product of two Q words
  // the full signed product is formed at double width, shifted right
  // arithmetically by the fraction bits and cut back to one word, so
  // anything above the word range wraps and the low bits truncate
  function automatic logic [`FFT_N-1:0] fixed_mul(
    input logic [`FFT_N-1:0] x,
    input logic [`FFT_N-1:0] y
  );
    logic signed [2*`FFT_N-1:0] prod;
    logic signed [2*`FFT_N-1:0] shifted;
    prod = $signed(x) * $signed(y);      // operands sign extend to the full width
    shifted = prod >>> `FFT_D;
    return shifted[`FFT_N-1:0];
  endfunction

endpackage

`default_nettype wire

// ==== logic/twiddle_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fft_params.svh"

// twiddle factors W8^k = exp(-j*2*pi*k/8) for the first half circle
module twiddle_rom (
  input  logic [`FFT_TW_BITS-1:0] k,
  output logic [`FFT_N-1:0]       tw_re,
  output logic [`FFT_N-1:0]       tw_im
);

  // 1.0 and cos(pi/4) in Q16.16, cos(pi/4) rounded from 46340.95
  localparam logic signed [`FFT_N-1:0] W_ONE  = 65536;
  localparam logic signed [`FFT_N-1:0] W_HALF = 46341;
  localparam logic signed [`FFT_N-1:0] W_ZERO = 0;

  always_comb begin
    case (k)
      2'd0: begin
        tw_re = W_ONE;             // angle 0
        tw_im = W_ZERO;
      end
      2'd1: begin
        tw_re = W_HALF;            // angle -pi/4
        tw_im = -W_HALF;
      end
      2'd2: begin
        tw_re = W_ZERO;            // angle -pi/2
        tw_im = -W_ONE;
      end
      2'd3: begin
        tw_re = -W_HALF;           // angle -3pi/4
        tw_im = -W_HALF;
      end
      default: begin
        tw_re = W_ONE;
        tw_im = W_ZERO;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the butterfly testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

TOP=tb_butterfly_top
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f butterfly.f \
  --top-module "$TOP" -Mdir obj_dir
./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"

// ==== sim/tb_butterfly_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fft_params.svh"

module tb_butterfly_top;

  localparam int LATENCY    = (`FFT_NUM_MULTS == 1) ? 5 : 1;
  localparam int HELD_MAX   = (`FFT_NUM_MULTS == 1) ? 2 : 1;   // results the DUT can hold
  localparam int DEPTH      = 256;
  localparam int MAX_CYCLES = 4000;   // about 200 ops at 12 cycles each, reset and some margin
  localparam logic [`FFT_N-1:0] Q_ONE = 32'h0001_0000;
  localparam logic [`FFT_N-1:0] Q_TWO = 32'h0002_0000;

  logic                    clk;
  logic                    reset;
  logic                    in_val;
  logic                    in_rdy;
  logic [`FFT_N-1:0]       a_re;
  logic [`FFT_N-1:0]       a_im;
  logic [`FFT_N-1:0]       b_re;
  logic [`FFT_N-1:0]       b_im;
  logic [`FFT_TW_BITS-1:0] k;
  logic                    out_val;
  logic                    out_rdy;
  logic [`FFT_N-1:0]       x0_re;
  logic [`FFT_N-1:0]       x0_im;
  logic [`FFT_N-1:0]       x1_re;
  logic [`FFT_N-1:0]       x1_im;

  integer seed;
  int     cycles;
  int     value_errors;
  int     proto_errors;
  int     issued;
  int     accepted;
  int     delivered;
  int     in_flight;
  int     stall_left;      // cycles that out_rdy is still forced low
  int     rdy_left;        // remaining length of the current out_rdy stretch
  logic   bp_on;
  logic   lat_phase;
  string  test_name;

  logic [4*`FFT_N-1:0] exp_mem [DEPTH];    // {x0_re, x0_im, x1_re, x1_im} in input order
  logic [7:0]          wr_ptr;
  logic [7:0]          rd_ptr;
  logic [4*`FFT_N-1:0] exp_front;
  logic [`FFT_N-1:0]   exp_x0_re;
  logic [`FFT_N-1:0]   exp_x0_im;
  logic [`FFT_N-1:0]   exp_x1_re;
  logic [`FFT_N-1:0]   exp_x1_im;

  butterfly_top butterfly_top_i (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .a_re    (a_re),
    .a_im    (a_im),
    .b_re    (b_re),
    .b_im    (b_im),
    .k       (k),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .x0_re   (x0_re),
    .x0_im   (x0_im),
    .x1_re   (x1_re),
    .x1_im   (x1_im)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Q16.16 product, low word of the sign extended 64 bit product taken above the fraction
  function automatic logic [`FFT_N-1:0] q_mul(input logic [`FFT_N-1:0] x,
                                              input logic [`FFT_N-1:0] y);
    logic [2*`FFT_N-1:0] xe;
    logic [2*`FFT_N-1:0] ye;
    logic [2*`FFT_N-1:0] full;
    xe   = {{`FFT_N{x[`FFT_N-1]}}, x};
    ye   = {{`FFT_N{y[`FFT_N-1]}}, y};
    full = xe * ye;
    return full[`FFT_D +: `FFT_N];
  endfunction

  // W8^k as {re, im}
  function automatic logic [2*`FFT_N-1:0] twiddle(input logic [`FFT_TW_BITS-1:0] kk);
    case (kk)
      2'd0:    return {32'sd65536, 32'sd0};
      2'd1:    return {32'sd46341, -32'sd46341};
      2'd2:    return {32'sd0, -32'sd65536};
      default: return {-32'sd46341, -32'sd46341};
    endcase
  endfunction

  function automatic logic [4*`FFT_N-1:0] butterfly_model(
    input logic [`FFT_N-1:0]       ar,
    input logic [`FFT_N-1:0]       ai,
    input logic [`FFT_N-1:0]       br,
    input logic [`FFT_N-1:0]       bi,
    input logic [`FFT_TW_BITS-1:0] kk
  );
    logic [2*`FFT_N-1:0] w;
    logic [`FFT_N-1:0]   p_rr;
    logic [`FFT_N-1:0]   p_ii;
    logic [`FFT_N-1:0]   p_sum;
    logic [`FFT_N-1:0]   pr;
    logic [`FFT_N-1:0]   pi;
    w     = twiddle(kk);
    p_rr  = q_mul(br, w[2*`FFT_N-1:`FFT_N]);
    p_ii  = q_mul(bi, w[`FFT_N-1:0]);
    p_sum = q_mul(br + bi, w[2*`FFT_N-1:`FFT_N] + w[`FFT_N-1:0]);
    pr    = p_rr - p_ii;
    pi    = p_sum - p_rr - p_ii;          // three-product form, wraps like the hardware
    return {ar + pr, ai + pi, ar - pr, ai - pi};
  endfunction

  // scoreboard, updated on the clock like the DUT registers
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      accepted  <= 0;
      delivered <= 0;
    end else begin
      if (in_val && in_rdy) begin
        exp_mem[wr_ptr] <= butterfly_model(a_re, a_im, b_re, b_im, k);
        wr_ptr          <= wr_ptr + 8'd1;
        accepted        <= accepted + 1;
      end
      if (out_val && out_rdy) begin
        rd_ptr    <= rd_ptr + 8'd1;
        delivered <= delivered + 1;
      end
    end
  end

  assign in_flight = accepted - delivered;
  assign exp_front = exp_mem[rd_ptr];
  assign exp_x0_re = exp_front[4*`FFT_N-1:3*`FFT_N];
  assign exp_x0_im = exp_front[3*`FFT_N-1:2*`FFT_N];
  assign exp_x1_re = exp_front[2*`FFT_N-1:`FFT_N];
  assign exp_x1_im = exp_front[`FFT_N-1:0];

  a_x0_re: assert property (@(posedge clk) disable iff (reset)
    out_val && out_rdy |-> x0_re == exp_x0_re) else begin
    value_errors++;
    $display("** Error %s x0_re: expected %h, actual %h", test_name,
             $sampled(exp_x0_re), $sampled(x0_re));
  end
  a_x0_im: assert property (@(posedge clk) disable iff (reset)
    out_val && out_rdy |-> x0_im == exp_x0_im) else begin
    value_errors++;
    $display("** Error %s x0_im: expected %h, actual %h", test_name,
             $sampled(exp_x0_im), $sampled(x0_im));
  end
  a_x1_re: assert property (@(posedge clk) disable iff (reset)
    out_val && out_rdy |-> x1_re == exp_x1_re) else begin
    value_errors++;
    $display("** Error %s x1_re: expected %h, actual %h", test_name,
             $sampled(exp_x1_re), $sampled(x1_re));
  end
  a_x1_im: assert property (@(posedge clk) disable iff (reset)
    out_val && out_rdy |-> x1_im == exp_x1_im) else begin
    value_errors++;
    $display("** Error %s x1_im: expected %h, actual %h", test_name,
             $sampled(exp_x1_im), $sampled(x1_im));
  end

  // an output with nothing accepted would be a spurious or duplicated result
  a_no_extra_output: assert property (@(posedge clk) disable iff (reset)
    out_val |-> in_flight > 0) else begin
    proto_errors++;
    $display("%s: out_val was high with no result pending", test_name);
  end

  a_hold_output: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(x0_re) && $stable(x0_im)
      && $stable(x1_re) && $stable(x1_im)) else begin
    proto_errors++;
    $display("%s: outputs dropped or changed while out_rdy was low", test_name);
  end

  // full means the output register and, with the shared unit, the multiplier are occupied
  a_stall_blocks: assert property (@(posedge clk) disable iff (reset)
    in_flight >= HELD_MAX && !out_rdy |-> !in_rdy) else begin
    proto_errors++;
    $display("%s: in_rdy was high while the DUT was full and stalled", test_name);
  end

  a_reset_idle: assert property (@(posedge clk)
    (cycles > 0) && $past(reset) |-> !out_val) else begin
    proto_errors++;
    $display("out_val was not low during or right after reset");
  end

  a_latency: assert property (@(posedge clk) disable iff (reset)
    $past(lat_phase && in_val && in_rdy, LATENCY) |-> $rose(out_val)) else begin
    proto_errors++;
    $display("%s: out_val did not rise %0d edges after acceptance", test_name, LATENCY);
  end

  task automatic next_cycle;
    @(posedge clk);
    #2;
    if (stall_left > 0) begin
      out_rdy    = 1'b0;
      stall_left = stall_left - 1;
    end else if (!bp_on) begin
      out_rdy = 1'b1;
    end else if (rdy_left > 0) begin
      rdy_left = rdy_left - 1;
    end else begin
      out_rdy  = !out_rdy;                 // start a new stretch at the other level
      rdy_left = $unsigned($random(seed)) % 6;
    end
  endtask

  // holds in_val and data until the scoreboard has seen the transfer
  task automatic send_op(input logic [`FFT_N-1:0] ar, input logic [`FFT_N-1:0] ai,
                         input logic [`FFT_N-1:0] br, input logic [`FFT_N-1:0] bi,
                         input logic [`FFT_TW_BITS-1:0] kk);
    int target;
    target = accepted + 1;
    in_val = 1'b1;
    a_re   = ar;
    a_im   = ai;
    b_re   = br;
    b_im   = bi;
    k      = kk;
    issued = issued + 1;
    do next_cycle(); while (accepted < target);
    in_val = 1'b0;
  endtask

  function automatic logic [`FFT_N-1:0] rand_word(input logic full_range);
    if (full_range) return $random(seed);
    return $random(seed) % 32'sd262144;    // within +-4.0
  endfunction

  task automatic send_random(input logic full_range);
    logic [`FFT_N-1:0] ar;
    logic [`FFT_N-1:0] ai;
    logic [`FFT_N-1:0] br;
    logic [`FFT_N-1:0] bi;
    logic [31:0]       r;
    ar = rand_word(full_range);
    ai = rand_word(full_range);
    br = rand_word(full_range);
    bi = rand_word(full_range);
    r  = $random(seed);
    send_op(ar, ai, br, bi, r[`FFT_TW_BITS-1:0]);
  endtask

  task automatic drain;
    while (delivered < accepted) next_cycle();
  endtask

  task automatic check_exact(input string name, input logic [4*`FFT_N-1:0] expected,
                             input logic [4*`FFT_N-1:0] actual);
    assert (actual == expected) else begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout after %0d cycles, %0d value errors, %0d protocol errors, %0d pending",
             cycles, value_errors, proto_errors, in_flight);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed         = 32'hd2bb_94fa;
    cycles       = 0;
    value_errors = 0;
    proto_errors = 0;
    issued       = 0;
    stall_left   = 0;
    rdy_left     = 0;
    bp_on        = 1'b0;
    lat_phase    = 1'b0;
    test_name    = "reset";
    reset        = 1'b1;
    in_val       = 1'b0;
    a_re         = '0;
    a_im         = '0;
    b_re         = '0;
    b_im         = '0;
    k            = '0;
    out_rdy      = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    reset   = 1'b0;
    out_rdy = 1'b1;

    test_name = "directed";
    // (1 + 0j) +- (2 + 1j) * W, exact for W = 1 and W = -j
    for (int i = 0; i < 4; i++) begin
      send_op(Q_ONE, '0, Q_TWO, Q_ONE, i[1:0]);
      drain();                             // the last result stays on the outputs
      if (i == 0) begin
        check_exact("directed_k0",
                    {32'h0003_0000, 32'h0001_0000, 32'hffff_0000, 32'hffff_0000},
                    {x0_re, x0_im, x1_re, x1_im});
      end else if (i == 2) begin
        check_exact("directed_k2",
                    {32'h0002_0000, 32'hfffe_0000, 32'h0000_0000, 32'h0002_0000},
                    {x0_re, x0_im, x1_re, x1_im});
      end
    end

    test_name = "idle";
    repeat (20) next_cycle();

    test_name = "random";
    for (int i = 0; i < 80; i++) send_random(i % 8 == 7);   // every eighth op wraps
    drain();

    test_name = "backpressure";
    bp_on = 1'b1;
    for (int i = 0; i < 60; i++) send_random(1'b0);
    bp_on = 1'b0;
    drain();

    test_name = "stall";
    for (int i = 0; i < 5; i++) begin
      stall_left = 12;
      out_rdy    = 1'b0;
      send_op(rand_word(1'b0), rand_word(1'b0), Q_ONE, Q_TWO, 2'd1);
      send_op(Q_TWO, Q_ONE, rand_word(1'b0), rand_word(1'b0), 2'd3);
      send_random(1'b0);                   // held with in_rdy low until the stall ends
      drain();
    end

    test_name = "latency";
    lat_phase = 1'b1;
    for (int i = 0; i < 16; i++) begin
      send_random(1'b0);
      drain();
      next_cycle();
    end
    lat_phase = 1'b0;
    next_cycle();

    if (accepted != issued || delivered != issued) begin
      proto_errors++;
      $display("%0d ops issued but %0d accepted and %0d delivered", issued, accepted, delivered);
    end
    $display("%0d value errors, %0d protocol errors, %0d results checked",
             value_errors, proto_errors, delivered);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
